/* compile.f */
hdl/lockstep_pkg.sv
hdl/core_in_if.sv
hdl/core_out_if.sv
hdl/shadow_reset_ctrl.sv
hdl/input_delay_line.sv
hdl/acc_core.sv
hdl/output_compare.sv
hdl/lockstep_top.sv
dv/lockstep_asserts.sv
dv/tb_lockstep.sv

/* dv/lockstep_asserts.sv */
// Concurrent checks on shadow reset sequencing and compare enable.
// One instance sits in the sequencer and one in the comparator.

`timescale 1ns/1ps

module lockstep_asserts #(
  parameter bit AT_SEQUENCER = 1'b1
) (
  input logic clk_i,
  input logic rst_ni,
  input logic cmp_en_i,
  // Shadow release flag in the sequencer, major alert in the comparator
  input logic flag_i
);

  int unsigned failures = 0;

  if (AT_SEQUENCER) begin : g_seq
    // Compare only runs once the shadow core is out of reset
    a_cmp_after_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmp_en_i |-> flag_i)
    else begin
      failures++;
      $error("cmp_en high while the shadow core is still in reset");
    end

    a_cmp_en_stays: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmp_en_i |=> cmp_en_i)
    else begin
      failures++;
      $error("cmp_en dropped without a reset");
    end
  end else begin : g_cmp
    a_alert_needs_cmp: assert property (@(posedge clk_i) flag_i |-> cmp_en_i)
    else begin
      failures++;
      $error("alert_major_o high while compare is disabled");
    end
  end

endmodule

bind shadow_reset_ctrl lockstep_asserts #(.AT_SEQUENCER(1'b1)) u_seq_asserts (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .cmp_en_i(cmp_en_o),
  .flag_i  (shadow_rst_no)
);

bind output_compare lockstep_asserts #(.AT_SEQUENCER(1'b0)) u_cmp_asserts (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .cmp_en_i(cmp_en_i),
  .flag_i  (alert_major_o)
);

/* dv/tb_lockstep.sv */
// Testbench for the lockstep checker.
// Plays the main accumulator core from a reference model, injects output
// faults and checks alert_major_o against the fault log delayed by OUTPUTS_OFFSET.

`timescale 1ns/1ps

module tb_lockstep import lockstep_pkg::*;;

  localparam int unsigned TIMEOUT = 20;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      req_valid;
  acc_op_e                   req_op;
  logic [OPERAND_W-1:0]      req_operand;
  logic                      rsp_ready;
  logic                      req_ready;
  logic                      rsp_valid;
  logic [ACC_W-1:0]          rsp_data;
  logic                      busy;
  logic                      alert_major;
  logic [ACC_W-1:0]          acc_q;
  logic                      held_q;
  logic [31:0]               rng;
  logic                      fault_cur;
  logic [OUTPUTS_OFFSET-1:0] fault_hist;
  int unsigned               errors;
  int unsigned               checks;

  lockstep_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid),
    .req_op_i     (req_op),
    .req_operand_i(req_operand),
    .rsp_ready_i  (rsp_ready),
    .req_ready_i  (req_ready),
    .rsp_valid_i  (rsp_valid),
    .rsp_data_i   (rsp_data),
    .busy_i       (busy),
    .alert_major_o(alert_major)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // One operation on the accumulator, operand zero-extended
  function automatic logic [ACC_W-1:0] apply_op(input logic [ACC_W-1:0] acc, input acc_op_e op,
                                                input logic [OPERAND_W-1:0] operand);
    logic [ACC_W-1:0] ext;
    ext = {{(ACC_W-OPERAND_W){1'b0}}, operand};
    case (op)
      OP_ADD:  return acc + ext;
      OP_SUB:  return acc - ext;
      OP_XOR:  return acc ^ ext;
      default: return ext;
    endcase
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  task automatic drive_outputs(input logic [ACC_W-1:0] data_flip, input logic ready_flip);
    req_ready = (!held_q || rsp_ready) ^ ready_flip;
    rsp_valid = held_q;
    rsp_data  = acc_q ^ data_flip;
    busy      = held_q;
    fault_cur = (data_flip != '0) || ready_flip;
  endtask

  // One cycle of the main core model: retire the last edge, drive new inputs
  task automatic step(input logic bp, input logic [ACC_W-1:0] data_flip, input logic ready_flip);
    logic accept;
    @(negedge clk_i);
    accept = req_valid && (!held_q || rsp_ready);
    if (accept) begin
      acc_q  = apply_op(acc_q, req_op, req_operand);
      held_q = 1'b1;
    end else if (rsp_ready) begin
      held_q = 1'b0;
    end
    // A pending request keeps its payload until it transfers
    if (!req_valid || accept) begin
      rng         = xorshift32(rng);
      req_valid   = rng[0] | rng[1] | ready_flip;
      req_op      = acc_op_e'(rng[3:2]);
      req_operand = rng[31:16];
    end
    rng       = xorshift32(rng);
    rsp_ready = bp ? rng[4] : 1'b1;
    drive_outputs(data_flip, ready_flip);
  endtask

  task automatic wait_alert(input string what, output int unsigned cycles);
    cycles = 0;
    while (!alert_major && cycles < TIMEOUT) begin
      step(1'b1, '0, 1'b0);
      cycles++;
    end
    if (!alert_major) begin
      errors++;
      $display("Timeout: alert_major_o never rose after the %s", what);
    end
  endtask

  // Compare process, expected alert is the fault log OUTPUTS_OFFSET edges back
  initial begin
    fault_hist = '0;
    forever begin
      @(posedge clk_i);
      if (!rst_ni) begin
        fault_hist = '0;
      end else begin
        fault_hist = {fault_hist[OUTPUTS_OFFSET-2:0], fault_cur};
      end
      @(negedge clk_i);
      check(32'(alert_major), 32'(fault_hist[OUTPUTS_OFFSET-1]), "alert_major_o vs fault log");
    end
  end

  initial begin
    int unsigned cycles;
    int unsigned base;
    errors = 0;
    checks = 0;
    rng    = 32'h24bc7572;
    acc_q  = '0;
    held_q = 1'b0;
    rst_ni = 1'b0;
    req_valid   = 1'b0;
    req_op      = OP_ADD;
    req_operand = '0;
    rsp_ready   = 1'b1;
    // Deliberately wrong outputs while reset holds the compare stages
    req_ready = 1'b0;
    rsp_valid = 1'b1;
    rsp_data  = 32'hdead_beef;
    busy      = 1'b1;
    fault_cur = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    drive_outputs('0, 1'b0);

    base = errors;
    repeat (10) step(1'b0, '0, 1'b0);
    $display("test startup: %0d errors", errors - base);

    base = errors;
    repeat (300) step(1'b0, '0, 1'b0);
    $display("test faithful traffic: %0d errors", errors - base);

    base = errors;
    repeat (300) step(1'b1, '0, 1'b0);
    $display("test back-pressure: %0d errors", errors - base);

    base = errors;
    step(1'b1, {{(ACC_W-1){1'b0}}, 1'b1} << rng[9:5], 1'b0);
    wait_alert("data fault", cycles);
    check(cycles, OUTPUTS_OFFSET, "data fault to alert delay");
    repeat (20) step(1'b1, '0, 1'b0);
    $display("test data fault: %0d errors", errors - base);

    base = errors;
    step(1'b1, '0, 1'b1);
    wait_alert("control fault", cycles);
    check(cycles, OUTPUTS_OFFSET, "control fault to alert delay");
    repeat (50) step(1'b1, '0, 1'b0);
    $display("test control fault: %0d errors", errors - base);

    errors += dut_i.u_shadow_reset_ctrl.u_seq_asserts.failures;
    errors += dut_i.u_output_compare.u_cmp_asserts.failures;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* hdl/acc_core.sv */
// Small accumulator core, instantiated as the shadow copy of the main core.
// Takes one operation per request handshake and returns the new running
// value one cycle later through a one-entry response register.

`timescale 1ns/1ps

module acc_core import lockstep_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  core_in_if.dst  in_if,
  core_out_if.src out_if
);

  logic [ACC_W-1:0] operand_ext;
  logic [ACC_W-1:0] acc_d;
  logic [ACC_W-1:0] acc_q;
  logic             rsp_valid_q;
  logic             req_ready;
  logic             accept;

  // Free when empty, or when the held response leaves this cycle
  assign req_ready = !rsp_valid_q || in_if.rsp_ready;
  assign accept    = in_if.req_valid && req_ready;

  assign operand_ext = ACC_W'(in_if.req_operand);

  always_comb begin
    acc_d = acc_q;
    case (in_if.req_op)
      OP_ADD: acc_d = acc_q + operand_ext;
      OP_SUB: acc_d = acc_q - operand_ext;
      OP_XOR: acc_d = acc_q ^ operand_ext;
      OP_CLR: acc_d = operand_ext;
      default: acc_d = acc_q;
    endcase
  end

  //////////////////////////////////////////////////
  // Accumulator doubles as the response payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      acc_q       <= acc_d;
      rsp_valid_q <= 1'b1;
    end else if (in_if.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign out_if.req_ready = req_ready;
  assign out_if.rsp_valid = rsp_valid_q;
  assign out_if.rsp_data  = acc_q;
  assign out_if.busy      = rsp_valid_q;

endmodule

/* hdl/core_in_if.sv */
// Bundle of everything that flows into an accumulator core.
// The src side drives the request and the response ready, dst receives them.

`timescale 1ns/1ps

interface core_in_if import lockstep_pkg::*;;

  logic                 req_valid;
  acc_op_e              req_op;
  logic [OPERAND_W-1:0] req_operand;
  logic                 rsp_ready;

  modport src (
    output req_valid, req_op, req_operand, rsp_ready
  );

  modport dst (
    input req_valid, req_op, req_operand, rsp_ready
  );

endinterface

/* hdl/core_out_if.sv */
// Bundle of everything an accumulator core drives.
// The core is the src side, the compare stage reads it as dst.

`timescale 1ns/1ps

interface core_out_if import lockstep_pkg::*;;

  logic             req_ready;
  logic             rsp_valid;
  logic [ACC_W-1:0] rsp_data;
  logic             busy;

  modport src (
    output req_ready, rsp_valid, rsp_data, busy
  );

  modport dst (
    input req_ready, rsp_valid, rsp_data, busy
  );

endinterface

/* hdl/input_delay_line.sv */
// Delays the main core's input bundle by LOCKSTEP_OFFSET cycles so the
// shadow core sees exactly the same inputs, the offset later.
// All stages reset to zero, leaving valid and ready inactive.

`timescale 1ns/1ps

module input_delay_line import lockstep_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  core_in_if.dst in_if,
  core_in_if.src out_if
);

  // Stage layout is {req_valid, req_op, req_operand, rsp_ready}
  logic [OPERAND_W+$bits(acc_op_e)+1:0] stage_d;
  logic [OPERAND_W+$bits(acc_op_e)+1:0] stage_q [LOCKSTEP_OFFSET];
  logic [$bits(acc_op_e)-1:0]           op_raw;

  assign stage_d = {in_if.req_valid, in_if.req_op, in_if.req_operand, in_if.rsp_ready};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < LOCKSTEP_OFFSET; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= stage_d;
      for (int i = 1; i < LOCKSTEP_OFFSET; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign {out_if.req_valid, op_raw, out_if.req_operand, out_if.rsp_ready} =
      stage_q[LOCKSTEP_OFFSET-1];

  assign out_if.req_op = acc_op_e'(op_raw);

endmodule

/* hdl/lockstep_pkg.sv */
// Shared constants and types for the lockstep checker and its accumulator core.
// Imported by wildcard in every module and interface header.

package lockstep_pkg;

  // Shadow core runs this many cycles behind the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;

  // Main outputs wait one more cycle to line up with the shadow output register
  localparam int unsigned OUTPUTS_OFFSET = LOCKSTEP_OFFSET + 1;

  // Reset sequencer counter width
  localparam int unsigned OFFSET_W = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  localparam int unsigned OPERAND_W = 16;
  localparam int unsigned ACC_W     = 32;

  // Operations on the accumulator, operand always zero-extended
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_CLR = 2'd3
  } acc_op_e;

endpackage

/* hdl/lockstep_top.sv */
// Top level of the lockstep checker.
// Observes the main core through plain ports, replays its inputs into a
// delayed shadow copy and compares both output sets. The main core itself
// lives outside; this block never applies back-pressure.

`timescale 1ns/1ps

module lockstep_top import lockstep_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Main core inputs
  input  logic                 req_valid_i,
  input  acc_op_e              req_op_i,
  input  logic [OPERAND_W-1:0] req_operand_i,
  input  logic                 rsp_ready_i,

  // Main core outputs
  input  logic                 req_ready_i,
  input  logic                 rsp_valid_i,
  input  logic [ACC_W-1:0]     rsp_data_i,
  input  logic                 busy_i,

  output logic                 alert_major_o
);

  logic shadow_rst_n;
  logic cmp_en;

  core_in_if  main_in ();
  core_in_if  shadow_in ();
  core_out_if main_out ();
  core_out_if shadow_out ();

  assign main_in.req_valid   = req_valid_i;
  assign main_in.req_op      = req_op_i;
  assign main_in.req_operand = req_operand_i;
  assign main_in.rsp_ready   = rsp_ready_i;

  assign main_out.req_ready = req_ready_i;
  assign main_out.rsp_valid = rsp_valid_i;
  assign main_out.rsp_data  = rsp_data_i;
  assign main_out.busy      = busy_i;

  shadow_reset_ctrl u_shadow_reset_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  input_delay_line u_input_delay_line (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .in_if (main_in),
    .out_if(shadow_in)
  );

  // Shadow copy of the main core
  acc_core u_shadow_core (
    .clk_i (clk_i),
    .rst_ni(shadow_rst_n),
    .in_if (shadow_in),
    .out_if(shadow_out)
  );

  output_compare u_output_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .main_if      (main_out),
    .shadow_if    (shadow_out),
    .cmp_en_i     (cmp_en),
    .alert_major_o(alert_major_o)
  );

endmodule

/* hdl/output_compare.sv */
// Output comparator of the lockstep pair.
// Main outputs go through OUTPUTS_OFFSET register stages, shadow outputs
// through one, so both arrive from the same input set. Any field difference
// while compare is enabled raises the major alert.

`timescale 1ns/1ps

module output_compare import lockstep_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  core_out_if.dst main_if,
  core_out_if.dst shadow_if,
  input  logic    cmp_en_i,
  output logic    alert_major_o
);

  // Bundle layout is {req_ready, rsp_valid, busy, rsp_data}
  logic [ACC_W+2:0] main_d;
  logic [ACC_W+2:0] main_q [OUTPUTS_OFFSET];
  logic [ACC_W+2:0] shadow_d;
  logic [ACC_W+2:0] shadow_q;

  assign main_d   = {main_if.req_ready, main_if.rsp_valid, main_if.busy, main_if.rsp_data};
  assign shadow_d = {shadow_if.req_ready, shadow_if.rsp_valid, shadow_if.busy,
                     shadow_if.rsp_data};

  //////////////////////////////////////////////////
  // Delay chains
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < OUTPUTS_OFFSET; i++) begin
        main_q[i] <= '0;
      end
      shadow_q <= '0;
    end else begin
      main_q[0] <= main_d;
      for (int i = 1; i < OUTPUTS_OFFSET; i++) begin
        main_q[i] <= main_q[i-1];
      end
      shadow_q <= shadow_d;
    end
  end

  // Not sticky, follows the registered sets cycle by cycle
  assign alert_major_o = cmp_en_i && (main_q[OUTPUTS_OFFSET-1] != shadow_q);

endmodule

/* hdl/shadow_reset_ctrl.sv */
// Reset sequencer for the shadow core.
// Holds the shadow in reset for LOCKSTEP_OFFSET cycles after rst_ni rises,
// releases it synchronously, and enables the compare one cycle later.

`timescale 1ns/1ps

module shadow_reset_ctrl import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  logic [OFFSET_W-1:0] cnt_q;
  logic                release_d;
  logic                release_q;
  logic                cmp_en_q;

  // Counter saturates once the offset is reached
  assign release_d = (cnt_q == OFFSET_W'(LOCKSTEP_OFFSET - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      release_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      if (!release_d) begin
        cnt_q <= cnt_q + 1'b1;
      end
      release_q <= release_d;
      cmp_en_q  <= release_q;
    end
  end

  assign shadow_rst_no = release_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the lockstep testbench with Verilator, runs it and looks for the pass line.
# Exits non-zero when the build fails or the pass line is missing.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_lockstep -o tb_lockstep &&
./obj_dir/tb_lockstep +verilator+error+limit+1000 | tee /dev/stderr |
  grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
